// File: hw/memAxiPkg.sv
`default_nettype none

package memAxiPkg;

  // ------------------------------------------------------------
  // bus widths
  // ------------------------------------------------------------
  parameter int IdWidth      = 8;
  parameter int AxiAddrWidth = 32;
  parameter int DataWidth    = 32;
  parameter int StrbWidth    = DataWidth / 8;      // one strobe per byte lane
  parameter int LaneBits     = $clog2(StrbWidth);  // address bits inside a word

  // ------------------------------------------------------------
  // encodings
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    burstFixed    = 2'b00,
    burstIncr     = 2'b01,
    burstWrap     = 2'b10,  // not supported, acts as fixed
    burstReserved = 2'b11   // undefined, acts as fixed
  } burst_e;

  typedef enum logic [1:0] {
    respOkay   = 2'b00,
    respSlvErr = 2'b10
  } resp_e;

  // ------------------------------------------------------------
  // channel payloads
  // ------------------------------------------------------------
  typedef struct packed {
    logic [IdWidth-1:0]      id;
    logic [AxiAddrWidth-1:0] addr;
    logic [7:0]              len;    // beats minus one
    logic [2:0]              size;   // log2 of bytes per beat
    burst_e                  burst;
  } axReq_t;  // shared by aw and ar

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [StrbWidth-1:0] strb;
    logic                 last;
  } wBeat_t;

  typedef struct packed {
    logic [IdWidth-1:0] id;
    resp_e              resp;
  } bRsp_t;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] data;
    resp_e                resp;
    logic                 last;
  } rBeat_t;

endpackage

`default_nettype wire

// File: hw/burstAddrGen.sv
`default_nettype none

module burstAddrGen #(
  parameter int AddrLength = 12
) (
  input  logic [AddrLength-1:0] addr,
  input  logic [2:0]            size,
  input  memAxiPkg::burst_e     burst,
  output logic [AddrLength-1:0] nextAddr
);

  import memAxiPkg::*;

  localparam int WordBits = AddrLength - LaneBits;

  logic [WordBits-1:0]   wordNext;  // following word index
  logic [AddrLength-1:0] stepNext;  // address plus bytes of one beat
  logic                  narrow;

  assign wordNext = addr[AddrLength-1:LaneBits] + WordBits'(1);
  assign stepNext = addr + (AddrLength'(1) << size);
  assign narrow   = ((32'd1 << size) < StrbWidth);

  // ------------------------------------------------------------
  // next beat address wrapping at memory size
  // ------------------------------------------------------------
  always_comb begin
    nextAddr = addr;  // fixed, wrap and reserved stay put
    if (burst == burstIncr) begin
      if (narrow) begin
        nextAddr = stepNext;
      end else begin
        nextAddr = {wordNext, {LaneBits{1'b0}}};  // align to next word
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/dualPortRam.sv
`default_nettype none

module dualPortRam #(
  parameter int AddrLength = 12
) (
  input  logic                                      ACLK,
  input  logic                                      wrEn,
  input  logic [AddrLength-memAxiPkg::LaneBits-1:0] wrAddr,
  input  logic [memAxiPkg::DataWidth-1:0]           wrData,
  input  logic [memAxiPkg::StrbWidth-1:0]           wrStrb,
  input  logic                                      rdEn,
  input  logic [AddrLength-memAxiPkg::LaneBits-1:0] rdAddr,
  output logic [memAxiPkg::DataWidth-1:0]           rdData
);

  import memAxiPkg::*;

  localparam int Depth = 2 ** (AddrLength - LaneBits);

  logic [DataWidth-1:0] mem [Depth];
  logic [DataWidth-1:0] fwdData;  // ram word merged with same-cycle write

  // ------------------------------------------------------------
  // write-first bypass per byte lane
  // ------------------------------------------------------------
  always_comb begin
    fwdData = mem[rdAddr];
    for (int b = 0; b < StrbWidth; b++) begin
      if (wrEn && wrStrb[b] && (wrAddr == rdAddr)) begin
        fwdData[8*b +: 8] = wrData[8*b +: 8];
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (wrEn) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (wrStrb[b]) begin
          mem[wrAddr][8*b +: 8] <= wrData[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (rdEn) begin
      rdData <= fwdData;  // one cycle read latency
    end
  end

endmodule

`default_nettype wire

// File: hw/axiWriteEngine.sv
`default_nettype none

module axiWriteEngine #(
  parameter int AddrLength = 12
) (
  input  logic                                      ACLK,
  input  logic                                      ARESETn,
  input  memAxiPkg::axReq_t                         awReq,
  input  logic                                      awValid,
  output logic                                      awReady,
  input  memAxiPkg::wBeat_t                         wBeat,
  input  logic                                      wValid,
  output logic                                      wReady,
  output memAxiPkg::bRsp_t                          bRsp,
  output logic                                      bValid,
  input  logic                                      bReady,
  output logic                                      ramWrEn,
  output logic [AddrLength-memAxiPkg::LaneBits-1:0] ramWrAddr,
  output logic [memAxiPkg::DataWidth-1:0]           ramWrData,
  output logic [memAxiPkg::StrbWidth-1:0]           ramWrStrb
);

  import memAxiPkg::*;

  typedef enum logic [1:0] {
    stIdle,
    stData,
    stResp
  } wState_e;

  wState_e               state;
  logic [IdWidth-1:0]    capId;
  logic [7:0]            capLen;
  logic [2:0]            capSize;
  burst_e                capBurst;
  logic [AddrLength-1:0] curAddr;   // byte address of the next beat
  logic [AddrLength-1:0] nextAddr;
  logic [7:0]            beatCnt;   // beats accepted so far
  logic                  awFire;
  logic                  wFire;
  logic                  finalBeat;

  assign awFire    = awValid && awReady;
  assign wFire     = wValid && wReady;   // wReady only high in stData
  assign finalBeat = (beatCnt == capLen);

  burstAddrGen #(
    .AddrLength(AddrLength)
  ) addrGen_i (
    .addr     (curAddr),
    .size     (capSize),
    .burst    (capBurst),
    .nextAddr (nextAddr)
  );

  // ------------------------------------------------------------
  // FSM and handshake flags
  // ------------------------------------------------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state   <= stIdle;
      awReady <= 1'b0;
      wReady  <= 1'b0;
      bValid  <= 1'b0;
      ramWrEn <= 1'b0;
      beatCnt <= '0;
    end else begin
      ramWrEn <= wFire;  // ram write one edge after the beat
      case (state)
        stIdle: begin
          if (awFire) begin
            awReady <= 1'b0;
            wReady  <= 1'b1;
            beatCnt <= '0;
            state   <= stData;
          end else begin
            awReady <= 1'b1;
          end
        end
        stData: begin
          if (wFire) begin
            beatCnt <= beatCnt + 8'd1;
            if (finalBeat) begin
              wReady <= 1'b0;
              bValid <= 1'b1;
              state  <= stResp;
            end
          end
        end
        stResp: begin
          if (bReady) begin
            bValid  <= 1'b0;
            awReady <= 1'b1;  // next request welcome
            state   <= stIdle;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  // ------------------------------------------------------------
  // request capture, ram write port and response payload
  // ------------------------------------------------------------
  always_ff @(posedge ACLK) begin
    if (awFire) begin
      capId    <= awReq.id;
      capLen   <= awReq.len;
      capSize  <= awReq.size;
      capBurst <= awReq.burst;
      curAddr  <= awReq.addr[AddrLength-1:0];
    end
    if (wFire) begin
      ramWrAddr <= curAddr[AddrLength-1:LaneBits];
      ramWrData <= wBeat.data;
      ramWrStrb <= wBeat.strb;
      curAddr   <= nextAddr;
      if (finalBeat) begin
        bRsp.id   <= capId;
        bRsp.resp <= wBeat.last ? respOkay : respSlvErr;  // missing wlast
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/axiReadEngine.sv
`default_nettype none

module axiReadEngine #(
  parameter int AddrLength = 12
) (
  input  logic                                      ACLK,
  input  logic                                      ARESETn,
  input  memAxiPkg::axReq_t                         arReq,
  input  logic                                      arValid,
  output logic                                      arReady,
  output memAxiPkg::rBeat_t                         rBeat,
  output logic                                      rValid,
  input  logic                                      rReady,
  output logic                                      ramRdEn,
  output logic [AddrLength-memAxiPkg::LaneBits-1:0] ramRdAddr,
  input  logic [memAxiPkg::DataWidth-1:0]           ramRdData
);

  import memAxiPkg::*;

  logic                  rdActive;   // burst in progress
  logic [IdWidth-1:0]    capId;
  logic [7:0]            capLen;
  logic [2:0]            capSize;
  burst_e                capBurst;
  logic [AddrLength-1:0] curAddr;    // byte address of the next ram read
  logic [AddrLength-1:0] nextAddr;
  logic [8:0]            issueCnt;   // ram reads issued, up to 256
  logic [7:0]            beatCnt;    // beats loaded into rBeat
  logic                  rdPending;  // ram data arrives this cycle
  logic                  holdValid;
  logic [DataWidth-1:0]  holdData;
  logic                  arFire;
  logic                  outFree;
  logic                  loadOut;
  logic                  loadHold;
  logic                  lastFire;

  assign arFire   = arValid && arReady;
  assign outFree  = !rValid || rReady;                       // rBeat may change
  assign loadOut  = outFree && (holdValid || rdPending);
  assign loadHold = rdPending && (holdValid || !outFree);    // catch word in flight
  assign lastFire = rValid && rReady && rBeat.last;

  // a read goes out only when its word is sure to find a slot
  assign ramRdEn   = rdActive && (issueCnt <= {1'b0, capLen}) && !holdValid && outFree;
  assign ramRdAddr = curAddr[AddrLength-1:LaneBits];

  burstAddrGen #(
    .AddrLength(AddrLength)
  ) addrGen_i (
    .addr     (curAddr),
    .size     (capSize),
    .burst    (capBurst),
    .nextAddr (nextAddr)
  );

  // ------------------------------------------------------------
  // control flags and counters
  // ------------------------------------------------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      rdActive  <= 1'b0;
      arReady   <= 1'b0;
      rValid    <= 1'b0;
      rdPending <= 1'b0;
      holdValid <= 1'b0;
      issueCnt  <= '0;
      beatCnt   <= '0;
    end else begin
      rdPending <= ramRdEn;
      if (!rdActive) begin
        if (arFire) begin
          arReady  <= 1'b0;
          rdActive <= 1'b1;
          issueCnt <= '0;
          beatCnt  <= '0;
        end else begin
          arReady <= 1'b1;
        end
      end
      if (ramRdEn) begin
        issueCnt <= issueCnt + 9'd1;
      end
      if (loadOut) begin
        rValid  <= 1'b1;
        beatCnt <= beatCnt + 8'd1;
      end else if (outFree) begin
        rValid <= 1'b0;
      end
      if (loadHold) begin
        holdValid <= 1'b1;
      end else if (loadOut) begin
        holdValid <= 1'b0;  // hold drained into rBeat
      end
      if (lastFire) begin
        rdActive <= 1'b0;
        arReady  <= 1'b1;   // same edge as rValid falling
      end
    end
  end

  // ------------------------------------------------------------
  // request capture and beat datapath
  // ------------------------------------------------------------
  always_ff @(posedge ACLK) begin
    if (arFire) begin
      capId    <= arReq.id;
      capLen   <= arReq.len;
      capSize  <= arReq.size;
      capBurst <= arReq.burst;
      curAddr  <= arReq.addr[AddrLength-1:0];
    end
    if (ramRdEn) begin
      curAddr <= nextAddr;
    end
    if (loadHold) begin
      holdData <= ramRdData;
    end
    if (loadOut) begin
      rBeat.id   <= capId;
      rBeat.data <= holdValid ? holdData : ramRdData;  // older word first
      rBeat.resp <= respOkay;
      rBeat.last <= (beatCnt == capLen);
    end
  end

endmodule

`default_nettype wire

// File: hw/memAxi.sv
`default_nettype none

module memAxi #(
  parameter int AddrLength = 12  // log2 of memory size in bytes
) (
  input  logic              ACLK,
  input  logic              ARESETn,
  input  memAxiPkg::axReq_t awReq,
  input  logic              awValid,
  output logic              awReady,
  input  memAxiPkg::wBeat_t wBeat,
  input  logic              wValid,
  output logic              wReady,
  output memAxiPkg::bRsp_t  bRsp,
  output logic              bValid,
  input  logic              bReady,
  input  memAxiPkg::axReq_t arReq,
  input  logic              arValid,
  output logic              arReady,
  output memAxiPkg::rBeat_t rBeat,
  output logic              rValid,
  input  logic              rReady
);

  import memAxiPkg::*;

  localparam int WordBits = AddrLength - LaneBits;

  logic                 ramWrEn;
  logic [WordBits-1:0]  ramWrAddr;
  logic [DataWidth-1:0] ramWrData;
  logic [StrbWidth-1:0] ramWrStrb;
  logic                 ramRdEn;
  logic [WordBits-1:0]  ramRdAddr;
  logic [DataWidth-1:0] ramRdData;

  // ------------------------------------------------------------
  // write path
  // ------------------------------------------------------------
  axiWriteEngine #(
    .AddrLength(AddrLength)
  ) wrEngine_i (
    .ACLK      (ACLK),
    .ARESETn   (ARESETn),
    .awReq     (awReq),
    .awValid   (awValid),
    .awReady   (awReady),
    .wBeat     (wBeat),
    .wValid    (wValid),
    .wReady    (wReady),
    .bRsp      (bRsp),
    .bValid    (bValid),
    .bReady    (bReady),
    .ramWrEn   (ramWrEn),
    .ramWrAddr (ramWrAddr),
    .ramWrData (ramWrData),
    .ramWrStrb (ramWrStrb)
  );

  // ------------------------------------------------------------
  // read path
  // ------------------------------------------------------------
  axiReadEngine #(
    .AddrLength(AddrLength)
  ) rdEngine_i (
    .ACLK      (ACLK),
    .ARESETn   (ARESETn),
    .arReq     (arReq),
    .arValid   (arValid),
    .arReady   (arReady),
    .rBeat     (rBeat),
    .rValid    (rValid),
    .rReady    (rReady),
    .ramRdEn   (ramRdEn),
    .ramRdAddr (ramRdAddr),
    .ramRdData (ramRdData)
  );

  dualPortRam #(
    .AddrLength(AddrLength)
  ) ram_i (
    .ACLK   (ACLK),
    .wrEn   (ramWrEn),
    .wrAddr (ramWrAddr),
    .wrData (ramWrData),
    .wrStrb (ramWrStrb),
    .rdEn   (ramRdEn),
    .rdAddr (ramRdAddr),
    .rdData (ramRdData)   // write-first on same word
  );

endmodule

`default_nettype wire

// File: tb/memAxi_properties.sv
`default_nettype none

module memAxiProperties (
  input logic              ACLK,
  input logic              ARESETn,
  input logic              awReady,
  input memAxiPkg::bRsp_t  bRsp,
  input logic              bValid,
  input logic              bReady,
  input memAxiPkg::rBeat_t rBeat,
  input logic              rValid,
  input logic              rReady
);

  timeunit 1ns;
  timeprecision 100ps;

  import memAxiPkg::*;

  int unsigned failCount = 0;  // failed assertions so far

  // ------------------------------------------------------------
  // write response channel
  // ------------------------------------------------------------
  bHoldsUntilReady: assert property (@(posedge ACLK) disable iff (!ARESETn)
    bValid && !bReady |=> bValid && $stable(bRsp))
    else begin
      failCount++;
      $error("bValid dropped or bRsp changed before bReady");
    end

  awIdleDuringResp: assert property (@(posedge ACLK) disable iff (!ARESETn)
    bValid |-> !awReady)
    else begin
      failCount++;
      $error("awReady high while a write response is pending");
    end

  // ------------------------------------------------------------
  // read data channel
  // ------------------------------------------------------------
  rBeatStable: assert property (@(posedge ACLK) disable iff (!ARESETn)
    rValid && !rReady |=> rValid && $stable(rBeat))
    else begin
      failCount++;
      $error("rBeat changed or rValid dropped while stalled");
    end

endmodule

bind memAxi memAxiProperties props_i (
  .ACLK    (ACLK),
  .ARESETn (ARESETn),
  .awReady (awReady),
  .bRsp    (bRsp),
  .bValid  (bValid),
  .bReady  (bReady),
  .rBeat   (rBeat),
  .rValid  (rValid),
  .rReady  (rReady)
);

`default_nettype wire

// File: tb/memAxiTb.sv
`default_nettype none

module memAxiTb;

  timeunit 1ns;
  timeprecision 100ps;

  import memAxiPkg::*;

  localparam int AddrLength = 12;
  localparam int MemBytes   = 2 ** AddrLength;
  localparam int ClkPeriod  = 100;
  localparam int Seed       = 51465;
  localparam int TestBeats  = 2 + 21 + 7 + 32 + 6;  // beats moved by all tests
  localparam int Margin     = 12;                   // cycles allowed per beat
  localparam int LimitCycles = TestBeats * Margin + 40;

  logic                 ACLK;
  logic                 ARESETn;
  axReq_t               awReq;
  logic                 awValid;
  logic                 awReady;
  wBeat_t               wBeat;
  logic                 wValid;
  logic                 wReady;
  bRsp_t                bRsp;
  logic                 bValid;
  logic                 bReady;
  axReq_t               arReq;
  logic                 arValid;
  logic                 arReady;
  rBeat_t               rBeat;
  logic                 rValid;
  logic                 rReady;

  logic [7:0]           model [MemBytes];  // byte image of the memory
  logic [DataWidth-1:0] beatData [256];    // payload of the next write
  logic [StrbWidth-1:0] beatStrb [256];
  rBeat_t               gotBeat [256];     // beats of the last read
  int                   gotCount;
  bRsp_t                gotRsp;
  string                testName;
  int                   errCount;
  int                   checkCount;
  int                   testCount;
  int                   testErrStart;

  memAxi #(
    .AddrLength(AddrLength)
  ) dut_i (
    .ACLK    (ACLK),
    .ARESETn (ARESETn),
    .awReq   (awReq),
    .awValid (awValid),
    .awReady (awReady),
    .wBeat   (wBeat),
    .wValid  (wValid),
    .wReady  (wReady),
    .bRsp    (bRsp),
    .bValid  (bValid),
    .bReady  (bReady),
    .arReq   (arReq),
    .arValid (arValid),
    .arReady (arReady),
    .rBeat   (rBeat),
    .rValid  (rValid),
    .rReady  (rReady)
  );

  initial begin
    ACLK = 1'b0;
    forever #(ClkPeriod / 2) ACLK = ~ACLK;
  end

  initial begin
    #(LimitCycles * ClkPeriod);
    $display("Watchdog expired after %0d cycles, a handshake never completed", LimitCycles);
    $display("STATUS: FAIL");
    $finish;
  end

  // ------------------------------------------------------------
  // reference model and checks
  // ------------------------------------------------------------
  function automatic axReq_t makeReq(input logic [IdWidth-1:0] id, input int addr,
                                     input int len, input int size, input burst_e burst);
    axReq_t req;
    req.id    = id;
    req.addr  = AxiAddrWidth'(addr);
    req.len   = 8'(len);
    req.size  = 3'(size);
    req.burst = burst;
    return req;
  endfunction

  function automatic int stepAddr(input int addr, input int size, input burst_e burst);
    int bytes;
    bytes = 1 << size;
    if (burst != burstIncr) return addr;  // fixed and undefined types stay put
    if (bytes < StrbWidth) return (addr + bytes) % MemBytes;
    return ((addr / StrbWidth + 1) * StrbWidth) % MemBytes;
  endfunction

  function automatic logic [DataWidth-1:0] modelWord(input int addr);
    logic [DataWidth-1:0] word;
    int base;
    base = addr - (addr % StrbWidth);
    for (int b = 0; b < StrbWidth; b++) begin
      word[8*b +: 8] = model[base + b];
    end
    return word;
  endfunction

  task automatic modelWrite(input int addr, input logic [DataWidth-1:0] data,
                            input logic [StrbWidth-1:0] strb);
    int base;
    base = addr - (addr % StrbWidth);
    for (int b = 0; b < StrbWidth; b++) begin
      if (strb[b]) model[base + b] = data[8*b +: 8];
    end
  endtask

  task automatic checkEq(input string what, input logic [DataWidth-1:0] expected,
                         input logic [DataWidth-1:0] actual);
    checkCount++;
    assert (actual === expected) else begin
      $display("Error %s %s: expected %h, actual %h", testName, what, expected, actual);
      errCount++;
    end
  endtask

  task automatic startTest(input string name);
    testName = name;
    testErrStart = errCount;
    testCount++;
  endtask

  task automatic endTest();
    $display("%s finished with %0d errors", testName, errCount - testErrStart);
  endtask

  task automatic fillRandom(input int beats);
    for (int i = 0; i < beats; i++) begin
      beatData[i] = DataWidth'($urandom);
      beatStrb[i] = '1;
    end
  endtask

  // ------------------------------------------------------------
  // bus drivers called right after a rising edge
  // ------------------------------------------------------------
  task automatic writeBurst(input axReq_t req, input bit dropLast);
    int addr;
    int beats;
    beats = int'(req.len) + 1;
    addr = int'(req.addr[AddrLength-1:0]);
    awReq <= req;
    awValid <= 1'b1;
    do begin
      @(posedge ACLK);
    end while (!awReady);
    awValid <= 1'b0;
    for (int i = 0; i < beats; i++) begin
      if (($urandom % 4) == 0) begin  // idle cycle on w now and then
        wValid <= 1'b0;
        @(posedge ACLK);
      end
      wBeat.data <= beatData[i];
      wBeat.strb <= beatStrb[i];
      wBeat.last <= (i == beats - 1) && !dropLast;
      wValid <= 1'b1;
      do begin
        @(posedge ACLK);
      end while (!wReady);
      modelWrite(addr, beatData[i], beatStrb[i]);
      addr = stepAddr(addr, int'(req.size), req.burst);
    end
    wValid <= 1'b0;
    do begin
      @(posedge ACLK);
    end while (!bValid);
    repeat ($urandom % 3) @(posedge ACLK);  // response left waiting a while
    bReady <= 1'b1;
    do begin
      @(posedge ACLK);
    end while (!bValid);
    gotRsp = bRsp;
    bReady <= 1'b0;
  endtask

  task automatic readBurst(input axReq_t req, input bit stall);
    bit done;
    done = 1'b0;
    gotCount = 0;
    arReq <= req;
    arValid <= 1'b1;
    do begin
      @(posedge ACLK);
    end while (!arReady);
    arValid <= 1'b0;
    while (!done) begin
      rReady <= (($urandom % 4) != 0) || !stall;  // about one stall in four
      @(posedge ACLK);
      if (rValid && rReady) begin
        gotBeat[gotCount] = rBeat;
        gotCount++;
        done = rBeat.last || (gotCount == 256);
      end
    end
    rReady <= 1'b0;
  endtask

  task automatic checkResp(input axReq_t req, input resp_e expected);
    checkEq("bresp", DataWidth'(expected), DataWidth'(gotRsp.resp));
    checkEq("bid", DataWidth'(req.id), DataWidth'(gotRsp.id));
  endtask

  task automatic checkReadBurst(input axReq_t req);
    int addr;
    int beats;
    beats = int'(req.len) + 1;
    addr = int'(req.addr[AddrLength-1:0]);
    checkEq("beat count", DataWidth'(beats), DataWidth'(gotCount));
    for (int i = 0; i < beats && i < gotCount; i++) begin
      checkEq($sformatf("beat %0d data", i), modelWord(addr), gotBeat[i].data);
      checkEq($sformatf("beat %0d last", i), DataWidth'(i == beats - 1),
              DataWidth'(gotBeat[i].last));
      checkEq($sformatf("beat %0d id", i), DataWidth'(req.id), DataWidth'(gotBeat[i].id));
      checkEq($sformatf("beat %0d resp", i), DataWidth'(respOkay),
              DataWidth'(gotBeat[i].resp));
      addr = stepAddr(addr, int'(req.size), req.burst);
    end
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------
  task automatic checkIdle(input string when);
    checkEq({"awReady ", when}, '0, DataWidth'(awReady));
    checkEq({"wReady ", when}, '0, DataWidth'(wReady));
    checkEq({"bValid ", when}, '0, DataWidth'(bValid));
    checkEq({"arReady ", when}, '0, DataWidth'(arReady));
    checkEq({"rValid ", when}, '0, DataWidth'(rValid));
  endtask

  task automatic resetState();
    startTest("resetState");
    for (int c = 0; c < 3; c++) begin
      @(posedge ACLK);
      if (c > 0) checkIdle("in reset");  // first edge resets at the latest
    end
    ARESETn <= 1'b1;
    @(posedge ACLK);
    checkIdle("after release");
    @(posedge ACLK);
    checkEq("awReady up", 1, DataWidth'(awReady));
    checkEq("arReady up", 1, DataWidth'(arReady));
    endTest();
  endtask

  task automatic singleWord();
    axReq_t req;
    startTest("singleWord");
    req = makeReq(8'h3C, 'h100, 0, LaneBits, burstIncr);
    fillRandom(1);
    writeBurst(req, 1'b0);
    checkResp(req, respOkay);
    req.id = 8'hA5;
    readBurst(req, 1'b0);
    checkReadBurst(req);
    endTest();
  endtask

  task automatic incrBurst();
    axReq_t req;
    startTest("incrBurst");
    req = makeReq(8'h11, 'h200, 7, LaneBits, burstIncr);
    fillRandom(8);
    writeBurst(req, 1'b0);
    checkResp(req, respOkay);
    req.id = 8'h12;
    readBurst(req, 1'b0);
    checkReadBurst(req);
    req = makeReq(8'h13, 'h300, StrbWidth - 1, 0, burstIncr);  // byte beats
    for (int i = 0; i < StrbWidth; i++) begin
      beatData[i] = DataWidth'($urandom);
      beatStrb[i] = StrbWidth'(1 << i);
    end
    writeBurst(req, 1'b0);
    checkResp(req, respOkay);
    req = makeReq(8'h14, 'h300, 0, LaneBits, burstIncr);
    readBurst(req, 1'b0);
    checkReadBurst(req);
    endTest();
  endtask

  task automatic fixedAndStrobe();
    axReq_t req;
    startTest("fixedAndStrobe");
    req = makeReq(8'h21, 'h400, 3, LaneBits, burstFixed);
    fillRandom(4);
    beatStrb[0] = 4'b0001;
    beatStrb[1] = 4'b0110;
    beatStrb[2] = 4'b1000;
    beatStrb[3] = 4'b0101;
    writeBurst(req, 1'b0);
    checkResp(req, respOkay);
    req = makeReq(8'h22, 'h400, 2, LaneBits, burstFixed);
    readBurst(req, 1'b0);
    checkReadBurst(req);
    endTest();
  endtask

  task automatic readBackPressure();
    axReq_t req;
    startTest("readBackPressure");
    req = makeReq(8'h31, 'h600, 15, LaneBits, burstIncr);
    fillRandom(16);
    writeBurst(req, 1'b0);
    checkResp(req, respOkay);
    req.id = 8'h32;
    readBurst(req, 1'b1);
    checkReadBurst(req);
    endTest();
  endtask

  task automatic writeResponse();
    axReq_t req;
    startTest("writeResponse");
    req = makeReq(8'h41, 'h700, 2, LaneBits, burstIncr);
    fillRandom(3);
    writeBurst(req, 1'b1);  // wlast missing on the final beat
    checkResp(req, respSlvErr);
    req = makeReq(8'h42, 'h710, 2, LaneBits, burstIncr);
    fillRandom(3);
    writeBurst(req, 1'b0);
    checkResp(req, respOkay);
    endTest();
  endtask

  initial begin
    void'($urandom(Seed));
    ARESETn = 1'b0;
    awReq = '0;
    awValid = 1'b0;
    wBeat = '0;
    wValid = 1'b0;
    bReady = 1'b0;
    arReq = '0;
    arValid = 1'b0;
    rReady = 1'b0;
    errCount = 0;
    checkCount = 0;
    testCount = 0;
    resetState();
    singleWord();
    incrBurst();
    fixedAndStrobe();
    readBackPressure();
    writeResponse();
    @(posedge ACLK);
    $display("%0d tests, %0d checks, %0d check errors, %0d assertion failures",
             testCount, checkCount, errCount, dut_i.props_i.failCount);
    if (errCount == 0 && dut_i.props_i.failCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: memAxi.f
hw/memAxiPkg.sv
hw/burstAddrGen.sv
hw/dualPortRam.sv
hw/axiWriteEngine.sv
hw/axiReadEngine.sv
hw/memAxi.sv
tb/memAxi_properties.sv
tb/memAxiTb.sv

// File: Makefile
TOOL       = verilator
TOP        = memAxiTb
FILELIST   = memAxi.f
FLAGS      = --binary --timing --assert --timescale 1ns/100ps -j 0
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/100ps
BUILD_DIR  = obj_dir
RUN_ARGS   = +verilator+error+limit+1000
LOG        = sim.log
FAIL_MSG   = STATUS: FAIL
SOURCES    = $(wildcard hw/*.sv tb/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
